// ==== build.f ====
+incdir+logic
logic/jtag_pkg.sv
logic/dmi_pkg.sv
logic/jtag_tap.sv
logic/dtm_regs.sv
logic/dmi_axil_master.sv
logic/dm_regfile.sv
logic/debug_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/dtm_asserts.sv
testbench/tb_debug_subsys.sv

// ==== Bender.yml ====
package:
  name: debug_subsys

sources:
  - include_dirs:
      - logic
    files:
      - logic/jtag_pkg.sv
      - logic/dmi_pkg.sv
      - logic/jtag_tap.sv
      - logic/dtm_regs.sv
      - logic/dmi_axil_master.sv
      - logic/dm_regfile.sv
      - logic/debug_subsys_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_clock_gen.sv
      - testbench/dtm_asserts.sv
      - testbench/tb_debug_subsys.sv

// ==== testbench/tb_debug_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dtm_cfg.svh"

module tb_debug_subsys
	import jtag_pkg::*, dmi_pkg::*;
();

	localparam int NUM_ENTRIES = 12;
	localparam int DMI_W       = `DTM_DMI_W;
	// Roughly 100 to 220 cycles per row plus start-up
	localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 200 + 500;

	// One row of the stimulus table
	typedef struct packed {
		logic [1:0]            op;
		logic [`DTM_ABITS-1:0] addr;
		logic [31:0]           data;
		logic [1:0]            exp_resp;
		logic [31:0]           exp_data;
	} entry_t;

	wire  TCK;
	wire  RSTn;
	logic TMS;
	logic TDI;
	wire  TDO;

	entry_t      stim_tab [NUM_ENTRIES];
	// Reference copy of the DM register file
	logic [31:0] ref_mem [`DM_WORDS];
	int          errors;
	int          checks;

	tb_clock_gen #(
		.PERIOD_NS    (4),
		.RESET_CYCLES (3)
	) i_clk (
		.TCK  (TCK),
		.RSTn (RSTn)
	);

	debug_subsys_top i_dut (
		.TCK  (TCK),
		.RSTn (RSTn),
		.TMS  (TMS),
		.TDI  (TDI),
		.TDO  (TDO)
	);

	bind debug_subsys_top dtm_asserts i_asserts (
		.TCK       (TCK),
		.RSTn      (RSTn),
		.tap_state (tap_state),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.busy      (busy),
		.awvalid   (awvalid),
		.awready   (awready),
		.wvalid    (wvalid),
		.wready    (wready),
		.arvalid   (arvalid),
		.arready   (arready)
	);

	task automatic check_value(input string name, input logic [63:0] got,
	                           input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
			         $time, name, got, exp);
		end
	endtask

	// Sample TDO for the present state and then set up TMS/TDI for the next edge
	// Always entered and left 1 ns after a rising edge
	task automatic jtag_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
		tdo_v = TDO;
		TMS   = tms_v;
		TDI   = tdi_v;
		@(posedge TCK);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		logic nc;
		repeat (n) jtag_step(1'b0, 1'b0, nc);
	endtask

	// Five TMS-high cycles then park in Run-Test/Idle
	task automatic tap_reset();
		logic nc;
		repeat (5) jtag_step(1'b1, 1'b0, nc);
		jtag_step(1'b0, 1'b0, nc);
	endtask

	// Run-Test/Idle to Run-Test/Idle through the IR column
	task automatic scan_ir(input ir_t code);
		logic       nc;
		logic       bit_out;
		logic [4:0] cap;
		jtag_step(1'b1, 1'b0, nc);
		jtag_step(1'b1, 1'b0, nc);
		jtag_step(1'b0, 1'b0, nc);
		jtag_step(1'b0, 1'b0, nc);
		for (int i = 0; i < 5; i++) begin
			jtag_step(i == 4, code[i], bit_out);
			cap[i] = bit_out;
		end
		jtag_step(1'b1, 1'b0, nc);
		jtag_step(1'b0, 1'b0, nc);
		// 1149.1 capture pattern
		check_value("ir_capture", cap, 5'b00001);
	endtask

	// LSB first and the last bit leaves Shift-DR
	task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
		logic nc;
		logic bit_out;
		dout = '0;
		jtag_step(1'b1, 1'b0, nc);
		jtag_step(1'b0, 1'b0, nc);
		jtag_step(1'b0, 1'b0, nc);
		for (int i = 0; i < len; i++) begin
			jtag_step(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		jtag_step(1'b1, 1'b0, nc);
		jtag_step(1'b0, 1'b0, nc);
	endtask

	// Request scan then idle cycles for the bus then a NOP scan for the result
	task automatic dmi_access(input logic [1:0] op, input logic [`DTM_ABITS-1:0] addr,
	                          input logic [31:0] data, output logic [1:0] resp,
	                          output logic [31:0] rdata,
	                          output logic [`DTM_ABITS-1:0] raddr);
		logic [63:0] din;
		logic [63:0] dout;
		din = '0;
		din[DMI_W-1:0] = {addr, data, op};
		scan_dr(DMI_W, din, dout);
		idle_cycles(8);
		din = '0;
		scan_dr(DMI_W, din, dout);
		resp  = dout[1:0];
		rdata = dout[33:2];
		raddr = dout[DMI_W-1 -: `DTM_ABITS];
	endtask

	// dtmcs read-back with optional dmireset and IR left at DMI
	task automatic check_dtmcs(input logic [1:0] exp_stat, input logic dmireset);
		logic [63:0] din;
		logic [63:0] dout;
		din     = '0;
		din[16] = dmireset;
		scan_ir(IR_DTMCS);
		scan_dr(32, din, dout);
		scan_ir(IR_DMI);
		check_value("dtmcs.version", dout[3:0], `DTM_VERSION);
		check_value("dtmcs.abits", dout[9:4], `DTM_ABITS);
		check_value("dtmcs.dmistat", dout[11:10], exp_stat);
	endtask

	// Fill one row and run the reference model for its expected result
	task automatic add_entry(input int idx, input dmi_op_t op,
	                         input logic [`DTM_ABITS-1:0] addr);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = (op == DMI_WRITE) ? $urandom() : 32'd0;
		e.exp_resp = (addr < `DM_WORDS) ? DMI_OK : DMI_FAILED;
		// Failed reads come back as zero
		e.exp_data = 32'd0;
		if (addr < `DM_WORDS) begin
			if (op == DMI_WRITE)
				ref_mem[addr] = e.data;
			else
				e.exp_data = ref_mem[addr];
		end
		stim_tab[idx] = e;
	endtask

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge TCK);
		$display("Watchdog expired after %0d TCK cycles, run did not complete",
		         WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [63:0]           dout;
		logic [1:0]            resp;
		logic [31:0]           rdata;
		logic [`DTM_ABITS-1:0] raddr;
		TMS    = 1'b1;
		TDI    = 1'b0;
		errors = 0;
		checks = 0;
		void'($urandom(36));
		for (int i = 0; i < `DM_WORDS; i++)
			ref_mem[i] = 32'd0;

		// Writes, read-backs, overwrite, out-of-range accesses
		add_entry(0, DMI_WRITE, 8'd3);
		add_entry(1, DMI_WRITE, 8'd7);
		add_entry(2, DMI_READ, 8'd3);
		add_entry(3, DMI_READ, 8'd7);
		add_entry(4, DMI_WRITE, 8'd15);
		add_entry(5, DMI_READ, 8'd15);
		add_entry(6, DMI_READ, 8'd0);
		add_entry(7, DMI_WRITE, 8'd3);
		add_entry(8, DMI_READ, 8'd3);
		add_entry(9, DMI_WRITE, 8'd20);
		add_entry(10, DMI_READ, 8'd200);
		add_entry(11, DMI_READ, 8'd7);

		@(posedge RSTn);
		@(posedge TCK);
		#1;
		idle_cycles(1);

		// IR comes out of reset on IDCODE
		scan_dr(32, 64'd0, dout);
		check_value("idcode", dout[31:0], `DTM_IDCODE);

		check_dtmcs(DMI_OK, 1'b0);

		for (int n = 0; n < NUM_ENTRIES; n++) begin
			dmi_access(stim_tab[n].op, stim_tab[n].addr, stim_tab[n].data,
			           resp, rdata, raddr);
			check_value("dmi.op", resp, stim_tab[n].exp_resp);
			check_value("dmi.address", raddr, stim_tab[n].addr);
			if (stim_tab[n].op == DMI_READ)
				check_value("dmi.data", rdata, stim_tab[n].exp_data);
			if (stim_tab[n].exp_resp == DMI_FAILED) begin
				// Sticky failure is cleared by the dmireset scan itself
				check_dtmcs(DMI_FAILED, 1'b1);
				check_dtmcs(DMI_OK, 1'b0);
			end
		end

		// TAP reset from IR=DMI
		tap_reset();
		scan_dr(32, 64'd0, dout);
		check_value("idcode", dout[31:0], `DTM_IDCODE);
		scan_ir(IR_DMI);
		// Register file untouched by the TAP reset
		dmi_access(DMI_READ, 8'd7, 32'd0, resp, rdata, raddr);
		check_value("dmi.op", resp, DMI_OK);
		check_value("dmi.data", rdata, ref_mem[7]);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/dtm_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtm_asserts
	import jtag_pkg::*;
(
	input wire            TCK,
	input wire            RSTn,
	input var tap_state_t tap_state,
	input wire            rd_req,
	input wire            wr_req,
	input wire            busy,
	input wire            awvalid,
	input wire            awready,
	input wire            wvalid,
	input wire            wready,
	input wire            arvalid,
	input wire            arready
);

	// Valids stay up until accepted
	aw_hold: assert property (@(posedge TCK) disable iff (!RSTn)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

	w_hold: assert property (@(posedge TCK) disable iff (!RSTn)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped before wready");

	ar_hold: assert property (@(posedge TCK) disable iff (!RSTn)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	// Strobes only reach an idle master
	req_idle: assert property (@(posedge TCK) disable iff (!RSTn)
		(rd_req || wr_req) |-> !busy)
		else $error("request strobe while the AXI master is busy");

	// First edge out of reset sees the TAP parked
	tap_reset_state: assert property (@(posedge TCK)
		$rose(RSTn) |-> tap_state == TEST_LOGIC_RESET)
		else $error("TAP not in Test-Logic-Reset after reset");

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic TCK,
	output logic RSTn
);

	// Free-running TCK
	initial begin
		TCK = 1'b0;
		forever #(PERIOD_NS / 2.0) TCK = ~TCK;
	end

	// Release just after a rising edge away from the sampling point
	initial begin
		RSTn = 1'b0;
		repeat (RESET_CYCLES) @(posedge TCK);
		#1;
		RSTn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== logic/debug_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dtm_cfg.svh"

module debug_subsys_top
	import jtag_pkg::*, dmi_pkg::*;
(
	input  wire  TCK,
	input  wire  RSTn,
	input  wire  TMS,
	input  wire  TDI,
	output logic TDO
);

	// TAP to DTM
	tap_state_t            tap_state;
	ir_t                   ir;
	logic                  ir_tdo;

	// DTM to AXI master
	logic                  rd_req;
	logic                  wr_req;
	logic [`DTM_ABITS-1:0] req_addr;
	logic [31:0]           req_data;
	logic                  busy;
	logic                  done;
	logic [31:0]           done_data;
	logic                  done_err;

	// AXI-lite write side
	logic [`DTM_ABITS-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [31:0]           wdata;
	logic [3:0]            wstrb;
	logic                  wvalid;
	logic                  wready;
	axi_resp_t             bresp;
	logic                  bvalid;
	logic                  bready;

	// AXI-lite read side
	logic [`DTM_ABITS-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [31:0]           rdata;
	axi_resp_t             rresp;
	logic                  rvalid;
	logic                  rready;

	jtag_tap i_tap (
		.tms (TMS),
		.tdi (TDI),
		.*
	);

	dtm_regs i_regs (
		.tdi (TDI),
		.tdo (TDO),
		.*
	);

	dmi_axil_master i_master (.*);

	dm_regfile i_regfile (.*);

endmodule

`default_nettype wire

// ==== logic/dm_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dtm_cfg.svh"

module dm_regfile
	import dmi_pkg::*;
(
	input  wire                   TCK,
	input  wire                   RSTn,
	input  wire  [`DTM_ABITS-1:0] awaddr,
	input  wire                   awvalid,
	output logic                  awready,
	input  wire  [31:0]           wdata,
	input  wire  [3:0]            wstrb,
	input  wire                   wvalid,
	output logic                  wready,
	output axi_resp_t             bresp,
	output logic                  bvalid,
	input  wire                   bready,
	input  wire  [`DTM_ABITS-1:0] araddr,
	input  wire                   arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output axi_resp_t             rresp,
	output logic                  rvalid,
	input  wire                   rready
);

	localparam int IDX_W = $clog2(`DM_WORDS);

	logic [31:0] regs [`DM_WORDS];
	logic        wr_fire;
	logic        wr_ok;
	logic        rd_ok;

	// AW and W taken together with one write in flight
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign arready = arvalid && !rvalid;

	// Word addresses beyond the file
	assign wr_ok = (awaddr < `DM_WORDS);
	assign rd_ok = (araddr < `DM_WORDS);

	always_ff @(posedge TCK or negedge RSTn) begin
		if (!RSTn) begin
			regs   <= '{default: '0};
			bvalid <= 1'b0;
			bresp  <= AXI_OKAY;
			rvalid <= 1'b0;
			rresp  <= AXI_OKAY;
		end else begin
			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= wr_ok ? AXI_OKAY : AXI_SLVERR;
				// Byte lanes
				if (wr_ok) begin
					for (int b = 0; b < 4; b++) begin
						if (wstrb[b])
							regs[awaddr[IDX_W-1:0]][8*b +: 8] <= wdata[8*b +: 8];
					end
				end
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (arready) begin
				rvalid <= 1'b1;
				rresp  <= rd_ok ? AXI_OKAY : AXI_SLVERR;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Out-of-range reads return zero
	always_ff @(posedge TCK) begin
		if (arready)
			rdata <= rd_ok ? regs[araddr[IDX_W-1:0]] : 32'd0;
	end

endmodule

`default_nettype wire

// ==== logic/dmi_axil_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dtm_cfg.svh"

module dmi_axil_master
	import dmi_pkg::*;
(
	input  wire                   TCK,
	input  wire                   RSTn,
	input  wire                   rd_req,
	input  wire                   wr_req,
	input  wire  [`DTM_ABITS-1:0] req_addr,
	input  wire  [31:0]           req_data,
	output logic                  busy,
	output logic                  done,
	output logic [31:0]           done_data,
	output logic                  done_err,
	output logic [`DTM_ABITS-1:0] awaddr,
	output logic                  awvalid,
	input  wire                   awready,
	output logic [31:0]           wdata,
	output logic [3:0]            wstrb,
	output logic                  wvalid,
	input  wire                   wready,
	input  var axi_resp_t         bresp,
	input  wire                   bvalid,
	output logic                  bready,
	output logic [`DTM_ABITS-1:0] araddr,
	output logic                  arvalid,
	input  wire                   arready,
	input  wire  [31:0]           rdata,
	input  var axi_resp_t         rresp,
	input  wire                   rvalid,
	output logic                  rready
);

	typedef enum logic [1:0] {M_IDLE, M_ADDR, M_RESP} mst_state_t;

	mst_state_t                state;
	logic                      is_write;
	logic [`DTM_ABITS-1:0]     addr_q;
	// Address phase finished when no valid is left unaccepted
	logic                      addr_done;

	assign addr_done = !(awvalid && !awready) && !(wvalid && !wready) &&
	                   !(arvalid && !arready);

	assign busy   = (state != M_IDLE);
	assign awaddr = addr_q;
	assign araddr = addr_q;
	// Full words only
	assign wstrb  = 4'hf;
	// Responses always accepted
	assign bready = 1'b1;
	assign rready = 1'b1;

	always_ff @(posedge TCK or negedge RSTn) begin
		if (!RSTn) begin
			state    <= M_IDLE;
			is_write <= 1'b0;
			awvalid  <= 1'b0;
			wvalid   <= 1'b0;
			arvalid  <= 1'b0;
			done     <= 1'b0;
			done_err <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (wr_req) begin
						awvalid  <= 1'b1;
						wvalid   <= 1'b1;
						is_write <= 1'b1;
						state    <= M_ADDR;
					end else if (rd_req) begin
						arvalid  <= 1'b1;
						is_write <= 1'b0;
						state    <= M_ADDR;
					end
				end
				M_ADDR: begin
					// AW and W may be taken in different cycles
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if (arready)
						arvalid <= 1'b0;
					if (addr_done)
						state <= M_RESP;
				end
				M_RESP: begin
					if (is_write ? bvalid : rvalid) begin
						done     <= 1'b1;
						done_err <= is_write ? (bresp == AXI_SLVERR) : (rresp == AXI_SLVERR);
						state    <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// Request and read payload
	always_ff @(posedge TCK) begin
		if (state == M_IDLE && (wr_req || rd_req))
			addr_q <= req_addr;
		if (state == M_IDLE && wr_req)
			wdata <= req_data;
		if (state == M_RESP && !is_write && rvalid)
			done_data <= rdata;
	end

endmodule

`default_nettype wire

// ==== logic/dtm_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dtm_cfg.svh"

module dtm_regs
	import jtag_pkg::*, dmi_pkg::*;
(
	input  wire                   TCK,
	input  wire                   RSTn,
	input  wire                   tdi,
	input  var tap_state_t        tap_state,
	input  var ir_t               ir,
	input  wire                   ir_tdo,
	input  wire                   busy,
	input  wire                   done,
	input  wire  [31:0]           done_data,
	input  wire                   done_err,
	output logic                  tdo,
	output logic                  rd_req,
	output logic                  wr_req,
	output logic [`DTM_ABITS-1:0] req_addr,
	output logic [31:0]           req_data
);

	localparam int AW = `DTM_ABITS;
	localparam int DW = `DTM_DMI_W;

	// Scan chains
	logic [31:0]   idcode_sr;
	logic [31:0]   dtmcs_sr;
	logic [DW-1:0] dmi_sr;

	// Persistent dmi result captured on every dmi scan
	logic [AW-1:0] res_addr;
	logic [31:0]   res_data;
	dmi_resp_t     res_op;
	logic          res_read;
	// Sticky error status for dtmcs
	dmi_resp_t     dmistat;

	dmi_op_t       upd_op;
	logic          dmi_start;
	logic          dtmcs_upd;

	assign upd_op    = dmi_op_t'(dmi_sr[1:0]);
	// Read or write update of dmi
	assign dmi_start = (tap_state == UPDATE_DR) && (ir == IR_DMI) &&
	                   ((upd_op == DMI_READ) || (upd_op == DMI_WRITE));
	assign dtmcs_upd = (tap_state == UPDATE_DR) && (ir == IR_DTMCS);

	// All chains capture together but only the selected one shifts
	always_ff @(posedge TCK) begin
		if (tap_state == CAPTURE_DR) begin
			idcode_sr <= `DTM_IDCODE;
			dtmcs_sr  <= {20'd0, dmistat, 6'(AW), 4'(`DTM_VERSION)};
			dmi_sr    <= {res_addr, res_data, res_op};
		end else if (tap_state == SHIFT_DR) begin
			case (ir)
				IR_IDCODE: idcode_sr <= {tdi, idcode_sr[31:1]};
				IR_DTMCS:  dtmcs_sr  <= {tdi, dtmcs_sr[31:1]};
				IR_DMI:    dmi_sr    <= {tdi, dmi_sr[DW-1:1]};
				default:   ;
			endcase
		end
	end

	// Request payload launched with the strobe
	always_ff @(posedge TCK) begin
		if (dmi_start && !busy) begin
			req_addr <= dmi_sr[DW-1 -: AW];
			req_data <= dmi_sr[33:2];
		end
	end

	always_ff @(posedge TCK or negedge RSTn) begin
		if (!RSTn) begin
			rd_req   <= 1'b0;
			wr_req   <= 1'b0;
			res_addr <= '0;
			res_data <= '0;
			res_op   <= DMI_OK;
			res_read <= 1'b0;
			dmistat  <= DMI_OK;
		end else begin
			rd_req <= 1'b0;
			wr_req <= 1'b0;
			// Transaction result from the AXI master
			if (done) begin
				res_op <= done_err ? DMI_FAILED : DMI_OK;
				if (res_read)
					res_data <= done_data;
				if (done_err)
					dmistat <= DMI_FAILED;
			end
			if (dmi_start && busy) begin
				// Dropped request keeps an earlier failure visible
				if (dmistat == DMI_OK)
					dmistat <= DMI_BUSY;
			end else if (dmi_start) begin
				rd_req   <= (upd_op == DMI_READ);
				wr_req   <= (upd_op == DMI_WRITE);
				res_addr <= dmi_sr[DW-1 -: AW];
				res_op   <= DMI_BUSY;
				res_read <= (upd_op == DMI_READ);
			end
			// dmireset
			if (dtmcs_upd && dtmcs_sr[16])
				dmistat <= DMI_OK;
		end
	end

	// TDO mux
	always_comb begin
		tdo = 1'b0;
		if (tap_state == SHIFT_IR) begin
			tdo = ir_tdo;
		end else if (tap_state == SHIFT_DR) begin
			case (ir)
				IR_IDCODE: tdo = idcode_sr[0];
				IR_DTMCS:  tdo = dtmcs_sr[0];
				IR_DMI:    tdo = dmi_sr[0];
				// Unknown codes see a 1-bit zero register
				default:   tdo = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/jtag_tap.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_tap
	import jtag_pkg::*;
(
	input  wire        TCK,
	input  wire        RSTn,
	input  wire        tms,
	input  wire        tdi,
	output tap_state_t tap_state,
	output ir_t        ir,
	output logic       ir_tdo
);

	tap_state_t state_nxt;
	// IR shift chain with the LSB going out first
	ir_t        ir_sr;

	// TAP graph with one transition per TCK
	always_comb begin
		case (tap_state)
			TEST_LOGIC_RESET: state_nxt = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
			SELECT_DR_SCAN:   state_nxt = tms ? SELECT_IR_SCAN   : CAPTURE_DR;
			CAPTURE_DR:       state_nxt = tms ? EXIT1_DR         : SHIFT_DR;
			SHIFT_DR:         state_nxt = tms ? EXIT1_DR         : SHIFT_DR;
			EXIT1_DR:         state_nxt = tms ? UPDATE_DR        : PAUSE_DR;
			PAUSE_DR:         state_nxt = tms ? EXIT2_DR         : PAUSE_DR;
			EXIT2_DR:         state_nxt = tms ? UPDATE_DR        : SHIFT_DR;
			UPDATE_DR:        state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
			SELECT_IR_SCAN:   state_nxt = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_nxt = tms ? EXIT1_IR         : SHIFT_IR;
			SHIFT_IR:         state_nxt = tms ? EXIT1_IR         : SHIFT_IR;
			EXIT1_IR:         state_nxt = tms ? UPDATE_IR        : PAUSE_IR;
			PAUSE_IR:         state_nxt = tms ? EXIT2_IR         : PAUSE_IR;
			EXIT2_IR:         state_nxt = tms ? UPDATE_IR        : SHIFT_IR;
			UPDATE_IR:        state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
			default:          state_nxt = TEST_LOGIC_RESET;
		endcase
	end

	// State and IR latch
	always_ff @(posedge TCK or negedge RSTn) begin
		if (!RSTn) begin
			tap_state <= TEST_LOGIC_RESET;
			ir        <= IR_IDCODE;
		end else begin
			tap_state <= state_nxt;
			// Five TMS-high cycles also land here and restore IDCODE
			if (tap_state == TEST_LOGIC_RESET)
				ir <= IR_IDCODE;
			else if (tap_state == UPDATE_IR)
				ir <= ir_sr;
		end
	end

	// IR chain
	// Capture pattern 0b00001 as 1149.1 requires
	always_ff @(posedge TCK) begin
		if (tap_state == CAPTURE_IR)
			ir_sr <= 5'b00001;
		else if (tap_state == SHIFT_IR)
			ir_sr <= {tdi, ir_sr[4:1]};
	end

	assign ir_tdo = ir_sr[0];

endmodule

`default_nettype wire

// ==== logic/dmi_pkg.sv ====
`default_nettype none

package dmi_pkg;

	// DMI op field on update
	typedef enum logic [1:0] {
		DMI_NOP   = 2'd0,
		DMI_READ  = 2'd1,
		DMI_WRITE = 2'd2
	} dmi_op_t;

	// DMI op field on capture and dmistat
	typedef enum logic [1:0] {
		DMI_OK     = 2'd0,
		DMI_FAILED = 2'd2,
		DMI_BUSY   = 2'd3
	} dmi_resp_t;

	// AXI-lite BRESP / RRESP subset
	typedef enum logic [1:0] {
		AXI_OKAY   = 2'd0,
		AXI_SLVERR = 2'd2
	} axi_resp_t;

endpackage

`default_nettype wire

// ==== logic/jtag_pkg.sv ====
`default_nettype none

package jtag_pkg;

	// IEEE 1149.1 TAP states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET = 4'd0,  RUN_TEST_IDLE = 4'd1,  SELECT_DR_SCAN = 4'd2,
		CAPTURE_DR       = 4'd3,  SHIFT_DR      = 4'd4,  EXIT1_DR       = 4'd5,
		PAUSE_DR         = 4'd6,  EXIT2_DR      = 4'd7,  UPDATE_DR      = 4'd8,
		SELECT_IR_SCAN   = 4'd9,  CAPTURE_IR    = 4'd10, SHIFT_IR       = 4'd11,
		EXIT1_IR         = 4'd12, PAUSE_IR      = 4'd13, EXIT2_IR       = 4'd14,
		UPDATE_IR        = 4'd15
	} tap_state_t;

	// Instruction register
	typedef logic [4:0] ir_t;

	localparam ir_t IR_IDCODE = 5'h01;
	localparam ir_t IR_DTMCS  = 5'h10;
	localparam ir_t IR_DMI    = 5'h11;

endpackage

`default_nettype wire

// ==== logic/dtm_cfg.svh ====
`ifndef DTM_CFG_SVH
`define DTM_CFG_SVH

// JTAG IDCODE
// Version 1, part 0x0dbe, manufacturer field left at 0x000
`define DTM_IDCODE 32'h10dbe001

// DMI address bits
`define DTM_ABITS 8

// dmi register width is address + data + op
`define DTM_DMI_W (`DTM_ABITS + 32 + 2)

// dtmcs version field of debug spec 0.13
`define DTM_VERSION 1

// Debug-module register file words
`define DM_WORDS 16

`endif
